/* hdl/ramBusPkg.sv */
// Bus-side types for the external SRAM manager
// USI control bus and UFI data bus requests and responses, plus CSR word layout

package ramBusPkg;

	// -------------------------------------------------------------------------
	// Widths and CSR map
	// -------------------------------------------------------------------------
	localparam int UFI_ID_W   = 3;
	localparam int RAM_ADRS_W = 19;
	localparam int RAM_DQ_W   = 8;

	localparam logic [15:0] CSR_CTRL   = 16'h0000;	// Enable and flush
	localparam logic [15:0] CSR_TIMING = 16'h0004;	// Wait-state count
	localparam logic [15:0] CSR_LASTRD = 16'h0008;	// Last SRAM read byte

	// USI control bus
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [31:0] adrs;	// Top byte selects the block
		logic [31:0] wd;
	} usiReqT;

	typedef struct packed {
		logic        valid;	// One-cycle strobe
		logic [31:0] rd;
	} usiRspT;

	// UFI data bus
	typedef struct packed {
		logic                  valid;
		logic                  cmd;	// High read, low write
		logic [RAM_ADRS_W-1:0] adrs;
		logic [RAM_DQ_W-1:0]   data;
		logic [UFI_ID_W-1:0]   id;
	} ufiReqT;

	typedef struct packed {
		logic                valid;
		logic [RAM_DQ_W-1:0] data;
		logic [UFI_ID_W-1:0] id;
	} ufiRspT;

	// Two views of one CSR write word
	typedef struct packed {
		logic [29:0] spare;
		logic        flush;	// Self-clearing
		logic        enable;
	} ctrlT;

	typedef struct packed {
		logic [27:0] spare;
		logic [3:0]  waitCycles;
	} timingT;

	typedef union packed {
		ctrlT   ctrl;
		timingT timing;
	} csrWordU;

endpackage

/* hdl/sramPkg.sv */
// Pin-side definitions for the asynchronous SRAM
// Strobe bundle, wait-state type and default timing

package sramPkg;

	// Wait states stretch the strobe low time
	typedef logic [3:0] waitT;

	localparam waitT WAIT_RESET = 4'd2;	// waitCycles after reset

	// SRAM pins, DQ carried as separate out and enable
	typedef struct packed {
		logic [ramBusPkg::RAM_ADRS_W-1:0] adrs;
		logic [ramBusPkg::RAM_DQ_W-1:0]   dqOut;
		logic                             dqOe;	// High drives DQ
		logic                             ceN;	// Chip enable
		logic                             oeN;	// Output enable
		logic                             weN;	// Write enable
	} sramPinsT;

endpackage

/* hdl/ramCsr.sv */
// CSR space of the SRAM manager on the USI bus
// Block decode, enable, flush and wait-state registers, last read byte

`timescale 1ns/1ps

module ramCsr #(
	parameter logic [7:0] blockAdrs = 8'h06
)(
	input  logic              sysClk,
	input  logic              rstN,
	input  ramBusPkg::usiReqT usiReq,
	output ramBusPkg::usiRspT usiRsp,
	input  ramBusPkg::ufiRspT lastRd,
	output logic              enable,
	output logic              flush,
	output sramPkg::waitT     waitCycles
);
	import ramBusPkg::*;
	import sramPkg::*;

	logic                hit;
	logic [15:0]         offset;
	csrWordU             wrWord;
	logic [RAM_DQ_W-1:0] lastByte;
	logic [31:0]         rdMux;

	assign hit    = usiReq.adrs[31:24] == blockAdrs;	// Block select
	assign offset = usiReq.adrs[15:0];
	assign wrWord = usiReq.wd;

	// ------------------------------------------------------------------------
	// Register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			enable     <= 1'b1;	// Engine runs out of reset
			flush      <= 1'b0;
			waitCycles <= WAIT_RESET;
		end
		else
		begin
			flush <= 1'b0;	// Strobe by default
			if (usiReq.wr && hit)
			begin
				case (offset)
					CSR_CTRL:
					begin
						enable <= wrWord.ctrl.enable;
						flush  <= wrWord.ctrl.flush;
					end
					CSR_TIMING: waitCycles <= wrWord.timing.waitCycles;
					default: ;	// Unmapped or read-only
				endcase
			end
		end
	end

	// Latch byte of every response strobe
	always_ff @(posedge sysClk)
	begin
		if (lastRd.valid)
			lastByte <= lastRd.data;
	end

	// ------------------------------------------------------------------------
	// Readback
	// ------------------------------------------------------------------------
	always_comb
	begin
		case (offset)
			CSR_CTRL:   rdMux = {31'd0, enable};	// Flush reads zero
			CSR_TIMING: rdMux = {28'd0, waitCycles};
			CSR_LASTRD: rdMux = {24'd0, lastByte};
			default:    rdMux = '0;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		usiRsp.rd <= rdMux;
		if (!rstN)
			usiRsp.valid <= 1'b0;
		else
			usiRsp.valid <= usiReq.rd && hit;	// Misses stay silent
	end

	// Master never issues both at once
	assert property (@(posedge sysClk) disable iff (!rstN) !(usiReq.wr && usiReq.rd));

endmodule

/* hdl/ufiCmdFifo.sv */
// UFI command queue
// Circular buffer with flush, entry count and ready level

`timescale 1ns/1ps

module ufiCmdFifo #(
	parameter int fifoDepth = 8
)(
	input  logic              sysClk,
	input  logic              rstN,
	input  ramBusPkg::ufiReqT push,
	input  logic              pop,
	input  logic              flush,
	output ramBusPkg::ufiReqT head,
	output logic              empty,
	output logic              rdy
);
	import ramBusPkg::*;

	localparam int PTR_W = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	ufiReqT           mem [0:fifoDepth-1];	// Entry storage
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0]   count;	// One extra bit for full
	logic             full;
	logic             doPush;
	logic             doPop;

	// Wrap at depth, also for odd depths
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(fifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full   = count == (PTR_W + 1)'(fifoDepth);
	assign empty  = count == '0;
	assign rdy    = !full;
	assign doPush = push.valid && !full;
	assign doPop  = pop && !empty;
	assign head   = mem[rdPtr];	// Valid in the pop cycle

	always_ff @(posedge sysClk)
	begin
		if (doPush)
			mem[wrPtr] <= push;
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;	// Both or neither
			endcase
		end
	end

	// Master honours rdy, unit honours empty
	assert property (@(posedge sysClk) disable iff (!rstN) push.valid |-> !full);
	assert property (@(posedge sysClk) disable iff (!rstN) pop |-> !empty);

endmodule

/* hdl/sramCtrl.sv */
// Wait-state sequencer for the asynchronous SRAM
// Drives CE, OE and WE, samples the read byte and returns it with its ID

`timescale 1ns/1ps

module sramCtrl (
	input  logic                              sysClk,
	input  logic                              rstN,
	input  ramBusPkg::ufiReqT                 cmd,
	input  logic                              start,
	output logic                              idle,
	input  sramPkg::waitT                     waitCycles,
	output sramPkg::sramPinsT                 sramPins,
	input  logic [ramBusPkg::RAM_DQ_W-1:0]    dqIn,
	output ramBusPkg::ufiRspT                 rsp
);
	import ramBusPkg::*;
	import sramPkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_ACTIVE, ST_RECOVER} stateT;

	stateT                 state;
	waitT                  cnt;	// Low cycles left
	logic                  ceN;
	logic                  oeN;
	logic                  weN;
	logic                  dqOe;
	logic                  rspValid;
	logic                  isRead;
	logic [RAM_ADRS_W-1:0] adrsQ;
	logic [RAM_DQ_W-1:0]   dataQ;
	logic [UFI_ID_W-1:0]   idQ;
	logic [RAM_DQ_W-1:0]   rdByte;
	logic                  lastLow;

	assign idle    = state == ST_IDLE;
	assign lastLow = (state == ST_ACTIVE) && (cnt == '0);

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			state    <= ST_IDLE;
			cnt      <= '0;
			ceN      <= 1'b1;
			oeN      <= 1'b1;
			weN      <= 1'b1;
			dqOe     <= 1'b0;
			rspValid <= 1'b0;
		end
		else
		begin
			rspValid <= 1'b0;
			case (state)
				ST_IDLE:
				if (start)
				begin
					state <= ST_ACTIVE;
					cnt   <= waitCycles;	// waitCycles+1 low cycles
					ceN   <= 1'b0;
					oeN   <= !cmd.cmd;
					weN   <= cmd.cmd;
					dqOe  <= !cmd.cmd;	// Drive DQ only on writes
				end
				ST_ACTIVE:
				if (lastLow)
				begin
					state    <= ST_RECOVER;
					ceN      <= 1'b1;
					oeN      <= 1'b1;
					weN      <= 1'b1;
					dqOe     <= 1'b0;
					rspValid <= isRead;	// Writes get no response
				end
				else
					cnt <= cnt - 1'b1;
				ST_RECOVER: state <= ST_IDLE;	// One idle cycle, strobes high
				default:    state <= ST_IDLE;
			endcase
		end
	end

	// Command payload, held for the whole access
	always_ff @(posedge sysClk)
	begin
		if (idle && start)
		begin
			isRead <= cmd.cmd;
			adrsQ  <= cmd.adrs;
			dataQ  <= cmd.data;
			idQ    <= cmd.id;
		end
		if (lastLow)
			rdByte <= dqIn;	// Sample in last low cycle
	end

	assign sramPins.adrs  = adrsQ;
	assign sramPins.dqOut = dataQ;
	assign sramPins.dqOe  = dqOe;
	assign sramPins.ceN   = ceN;
	assign sramPins.oeN   = oeN;
	assign sramPins.weN   = weN;

	assign rsp.valid = rspValid;
	assign rsp.data  = rdByte;
	assign rsp.id    = idQ;

	// Read and write strobes are exclusive on the pins
	assert property (@(posedge sysClk) disable iff (!rstN) sramPins.weN || sramPins.oeN);

endmodule

/* hdl/ramUnit.sv */
// SRAM engine of the manager
// Command queue feeding the wait-state sequencer, issue gated by enable

`timescale 1ns/1ps

module ramUnit #(
	parameter int fifoDepth = 8
)(
	input  logic                           sysClk,
	input  logic                           rstN,
	input  ramBusPkg::ufiReqT              ufiReq,
	output ramBusPkg::ufiRspT              ufiRsp,
	output logic                           rdy,
	input  logic                           enable,
	input  logic                           flush,
	input  sramPkg::waitT                  waitCycles,
	output sramPkg::sramPinsT              sramPins,
	input  logic [ramBusPkg::RAM_DQ_W-1:0] dqIn
);
	import ramBusPkg::*;

	ufiReqT head;	// Oldest queued command
	logic   empty;
	logic   ctrlIdle;
	logic   pop;

	// Pop only what the sequencer can take now
	assign pop = ctrlIdle && !empty && enable;

	ufiCmdFifo #(
		.fifoDepth  (fifoDepth)
	) ufiCmdFifo_inst (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.push       (ufiReq),
		.pop        (pop),
		.flush      (flush),
		.head       (head),
		.empty      (empty),
		.rdy        (rdy)
	);

	sramCtrl sramCtrl_inst (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.cmd        (head),
		.start      (pop),
		.idle       (ctrlIdle),
		.waitCycles (waitCycles),
		.sramPins   (sramPins),
		.dqIn       (dqIn),
		.rsp        (ufiRsp)
	);

endmodule

/* hdl/ramBlock.sv */
// External SRAM manager, top level
// UFI data path through ramUnit, USI control through ramCsr

`timescale 1ns/1ps

module ramBlock #(
	parameter logic [7:0] blockAdrs = 8'h06,	// USI block select
	parameter int         fifoDepth = 8	// Command queue entries
)(
	input  logic                           sysClk,
	input  logic                           rstN,
	input  ramBusPkg::usiReqT              usiReq,
	output ramBusPkg::usiRspT              usiRsp,
	input  ramBusPkg::ufiReqT              ufiReq,
	output ramBusPkg::ufiRspT              ufiRsp,
	output logic                           rdy,
	output sramPkg::sramPinsT              sramPins,
	input  logic [ramBusPkg::RAM_DQ_W-1:0] dqIn
);
	import sramPkg::*;

	logic enable;
	logic flush;
	waitT waitCycles;

	ramUnit #(
		.fifoDepth  (fifoDepth)
	) ramUnit_inst (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.ufiReq     (ufiReq),
		.ufiRsp     (ufiRsp),
		.rdy        (rdy),
		.enable     (enable),
		.flush      (flush),
		.waitCycles (waitCycles),
		.sramPins   (sramPins),
		.dqIn       (dqIn)
	);

	// Response also feeds the last read CSR
	ramCsr #(
		.blockAdrs  (blockAdrs)
	) ramCsr_inst (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.usiReq     (usiReq),
		.usiRsp     (usiRsp),
		.lastRd     (ufiRsp),
		.enable     (enable),
		.flush      (flush),
		.waitCycles (waitCycles)
	);

endmodule

/* testbench/sramModel.sv */
// Behavioral asynchronous SRAM for the testbench
// Byte array written while CE and WE are low, read while CE and OE are low

`timescale 1ns/1ps

module sramModel (
	input  sramPkg::sramPinsT              pins,
	output logic [ramBusPkg::RAM_DQ_W-1:0] dqIn
);
	import ramBusPkg::*;

	localparam int DEPTH = 1 << RAM_ADRS_W;

	logic [RAM_DQ_W-1:0] mem [0:DEPTH-1];	// Whole 2^19 byte array

	// Address-dependent fill first, then follow the pins
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem[RAM_ADRS_W'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);
		forever
		begin
			@(pins);
			// Level write, final pin state wins
			if (!pins.ceN && !pins.weN && pins.dqOe)
				mem[pins.adrs] = pins.dqOut;
		end
	end

	// Undriven DQ modelled as zero
	assign dqIn = (!pins.ceN && !pins.oeN) ? mem[pins.adrs] : '0;

endmodule

/* testbench/ramBlockTb.sv */
// Testbench for the external SRAM manager
// Directed tests over the UFI data bus and the USI CSR bus

`timescale 1ns/1ps

module ramBlockTb;
	import ramBusPkg::*;
	import sramPkg::*;

	localparam int         CLK_PERIOD = 20;
	localparam int         TEST_COUNT = 6;
	localparam int         RSP_WAIT   = 200;	// Cycles allowed for one access
	localparam logic [7:0] BLK        = 8'h06;
	localparam sramPinsT   PINS_IDLE  = '{adrs: '0, dqOut: '0, dqOe: 1'b0,
		ceN: 1'b1, oeN: 1'b1, weN: 1'b1};	// Strobes parked high

	logic                sysClk;
	logic                rstN;
	usiReqT              usiReq;
	usiRspT              usiRsp;
	ufiReqT              ufiReq;
	ufiRspT              ufiRsp;
	logic                rdy;
	sramPinsT            sramPins;
	logic [RAM_DQ_W-1:0] dqIn;
	waitT                expWait;	// Wait count the CSR should hold

	ramBlock #(
		.blockAdrs  (BLK),
		.fifoDepth  (8)
	) ramBlock_inst (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.usiReq     (usiReq),
		.usiRsp     (usiRsp),
		.ufiReq     (ufiReq),
		.ufiRsp     (ufiRsp),
		.rdy        (rdy),
		.sramPins   (sramPins),
		.dqIn       (dqIn)
	);

	sramModel sramModel_inst (
		.pins       (sramPins),
		.dqIn       (dqIn)
	);

	initial
	begin
		sysClk = 1'b0;
		forever
			#(CLK_PERIOD / 2) sysClk = ~sysClk;
	end

	// Generous bound over all tests
	initial
	begin
		#(CLK_PERIOD * (TEST_COUNT * 2000 + 1000));
		stopRun("Watchdog expired, the tests hung and never reached the end");
	end

	// ------------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------------------
	task automatic stopRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkUfiRsp(input ufiRspT got, input ufiRspT exp, input string what);
		if (got !== exp)
			stopRun($sformatf("FAIL %0t: %s got v%0b %h id%0d, expected v%0b %h id%0d",
				$time, what, got.valid, got.data, got.id, exp.valid, exp.data, exp.id));
	endtask

	task automatic checkUsiRsp(input usiRspT got, input usiRspT exp, input string what);
		if (got !== exp)
			stopRun($sformatf("FAIL %0t: %s got v%0b %h, expected v%0b %h",
				$time, what, got.valid, got.rd, exp.valid, exp.rd));
	endtask

	// Strobes and DQ enable only
	task automatic checkStrobes(input sramPinsT got, input sramPinsT exp, input string what);
		if ({got.ceN, got.oeN, got.weN, got.dqOe} !== {exp.ceN, exp.oeN, exp.weN, exp.dqOe})
			stopRun($sformatf("FAIL %0t: %s got ce/oe/we/oe %b%b%b%b, expected %b%b%b%b",
				$time, what, got.ceN, got.oeN, got.weN, got.dqOe,
				exp.ceN, exp.oeN, exp.weN, exp.dqOe));
	endtask

	task automatic checkInt(input int got, input int exp, input string what);
		if (got != exp)
			stopRun($sformatf("FAIL %0t: %s got %0d, expected %0d", $time, what, got, exp));
	endtask

	// ------------------------------------------------------------------------
	// Bus drivers
	// ------------------------------------------------------------------------
	task automatic usiWrite(input logic [7:0] blk, input logic [15:0] off,
		input logic [31:0] data);
		@(posedge sysClk);
		usiReq <= '{wr: 1'b1, rd: 1'b0, adrs: {blk, 8'h00, off}, wd: data};
		@(posedge sysClk);
		usiReq <= '0;
	endtask

	task automatic usiRead(input logic [7:0] blk, input logic [15:0] off,
		output usiRspT rsp);
		@(posedge sysClk);
		usiReq <= '{wr: 1'b0, rd: 1'b1, adrs: {blk, 8'h00, off}, wd: 32'd0};
		@(posedge sysClk);
		usiReq <= '0;
		@(negedge sysClk);
		rsp = usiRsp;	// One cycle after the request edge
	endtask

	// Strobe only once rdy is seen high
	task automatic ufiSend(input logic isRd, input logic [RAM_ADRS_W-1:0] adrs,
		input logic [RAM_DQ_W-1:0] data, input logic [UFI_ID_W-1:0] id);
		int waited;
		waited = 0;
		@(negedge sysClk);
		while (!rdy)
		begin
			waited++;
			if (waited > 2000)
				stopRun("rdy stayed low, the command queue never drained");
			@(negedge sysClk);
		end
		@(posedge sysClk);
		ufiReq <= '{valid: 1'b1, cmd: isRd, adrs: adrs, data: data, id: id};
		@(posedge sysClk);
		ufiReq <= '0;
	endtask

	task automatic awaitUfiRsp(output ufiRspT rsp);
		int waited;
		waited = 0;
		@(negedge sysClk);
		while (!ufiRsp.valid)
		begin
			waited++;
			if (waited > RSP_WAIT)
				stopRun("No UFI read response arrived within the wait limit");
			@(negedge sysClk);
		end
		rsp = ufiRsp;
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic resetState();
		usiRspT rsp;
		@(negedge sysClk);
		checkStrobes(sramPins, PINS_IDLE, "pins after reset");
		checkInt(int'(rdy), 1, "rdy after reset");
		checkInt(int'(ufiRsp.valid), 0, "UFI valid after reset");
		checkInt(int'(usiRsp.valid), 0, "USI valid after reset");
		usiRead(BLK, CSR_TIMING, rsp);
		checkUsiRsp(rsp, '{valid: 1'b1, rd: {28'd0, WAIT_RESET}}, "timing after reset");
	endtask

	task automatic writeThenRead();
		ufiRspT rsp;
		ufiSend(1'b0, 19'h1234A, 8'hA5, 3'd1);
		ufiSend(1'b1, 19'h1234A, 8'h00, 3'd5);
		awaitUfiRsp(rsp);
		checkUfiRsp(rsp, '{valid: 1'b1, data: 8'hA5, id: 3'd5}, "read of 0x1234a");
		checkInt(int'(sramModel_inst.mem[19'h1234A]), 'hA5, "model byte at 0x1234a");
	endtask

	task automatic waitStates();
		usiRspT rsp;
		int     waited;
		int     lowCycles;
		usiWrite(BLK, CSR_TIMING, 32'd5);
		expWait = 4'd5;
		usiRead(BLK, CSR_TIMING, rsp);
		checkUsiRsp(rsp, '{valid: 1'b1, rd: {28'd0, expWait}}, "timing readback");
		ufiSend(1'b0, 19'h00777, 8'h3C, 3'd2);
		waited = 0;
		@(negedge sysClk);
		while (sramPins.weN)
		begin
			waited++;
			if (waited > RSP_WAIT)
				stopRun("weN never went low for the queued write");
			@(negedge sysClk);
		end
		lowCycles = 0;
		while (!sramPins.weN)
		begin
			lowCycles++;
			@(negedge sysClk);
		end
		checkInt(lowCycles, int'(expWait) + 1, "weN low cycles");	// Wait states plus one
	endtask

	task automatic pauseAndFlush();
		logic [RAM_ADRS_W-1:0] adrs [0:2];
		logic [RAM_DQ_W-1:0]   snap [0:2];
		for (int k = 0; k < 3; k++)
			adrs[k] = RAM_ADRS_W'((k + 1) * 'h101);
		usiWrite(BLK, CSR_CTRL, 32'h0);	// Pause the engine
		for (int k = 0; k < 3; k++)
			snap[k] = sramModel_inst.mem[adrs[k]];
		for (int k = 0; k < 3; k++)
			ufiSend(1'b0, adrs[k], ~snap[k], 3'(k));
		usiWrite(BLK, CSR_CTRL, 32'h2);	// Flush while still paused
		usiWrite(BLK, CSR_CTRL, 32'h1);
		repeat (40)
		begin
			@(negedge sysClk);
			checkStrobes(sramPins, PINS_IDLE, "pins in the quiet window");
		end
		for (int k = 0; k < 3; k++)
			checkInt(int'(sramModel_inst.mem[adrs[k]]), int'(snap[k]), "model byte after flush");
	endtask

	task automatic randomTraffic();
		logic [RAM_ADRS_W-1:0] refAdrs [0:19];
		logic [RAM_DQ_W-1:0]   refData [0:19];
		logic [31:0]           r;
		ufiRspT                rsp;
		usiRspT                csrRsp;
		for (int i = 0; i < 20; i++)
		begin
			r = $urandom;
			refAdrs[i] = {r[18:5], 5'(i)};	// Low bits keep addresses distinct
			refData[i] = r[31:24];
			ufiSend(1'b0, refAdrs[i], refData[i], 3'(i));
		end
		for (int i = 0; i < 20; i++)
		begin
			ufiSend(1'b1, refAdrs[i], 8'h00, 3'(i));
			awaitUfiRsp(rsp);
			checkUfiRsp(rsp, '{valid: 1'b1, data: refData[i], id: 3'(i)}, "random read");
		end
		usiRead(BLK, CSR_LASTRD, csrRsp);
		checkUsiRsp(csrRsp, '{valid: 1'b1, rd: {24'd0, refData[19]}}, "last read byte");
	endtask

	task automatic blockDecode();
		usiRspT rsp;
		usiRead(BLK ^ 8'h01, CSR_TIMING, rsp);
		checkInt(int'(rsp.valid), 0, "response valid on another block");
		usiWrite(BLK ^ 8'h01, CSR_TIMING, 32'd9);	// Must be ignored
		usiRead(BLK, CSR_TIMING, rsp);
		checkUsiRsp(rsp, '{valid: 1'b1, rd: {28'd0, expWait}}, "timing after missed write");
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		usiReq <= '0;
		ufiReq <= '0;
		rstN   <= 1'b0;
		expWait = WAIT_RESET;
		void'($urandom(85519));
		repeat (3) @(posedge sysClk);
		rstN <= 1'b1;
		resetState();
		writeThenRead();
		waitStates();
		pauseAndFlush();
		randomTraffic();
		blockDecode();
		$display("sim passed");
		$finish;
	end

endmodule

/* flist.f */
hdl/ramBusPkg.sv
hdl/sramPkg.sv
hdl/ramCsr.sv
hdl/ufiCmdFifo.sv
hdl/sramCtrl.sv
hdl/ramUnit.sv
hdl/ramBlock.sv
testbench/sramModel.sv
testbench/ramBlockTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SRAM manager testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ramBlockTb -f flist.f -o ramBlockSim &&
./obj_dir/ramBlockSim ||
{ echo "build or simulation error"; exit 1; }
